// File: wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// =========================================================================
// datapath sizing
// =========================================================================

// width of one data word
`define WB_DATA_WIDTH 32

// destination register number width, enough for the whole register file
`define WB_REG_ADDR_WIDTH 6

// register file entries, entry 0 always reads zero
`define WB_NUM_REGS 64

// one quotient bit per iteration
`define WB_DIV_ITERS 32

// data memory depth in words, word addressed
`define WB_MEM_WORDS 256

`endif

// File: wb_pkg.sv
`include "wb_params.svh"

package wb_pkg;

    typedef logic [`WB_DATA_WIDTH-1:0] data_t;

    typedef logic [`WB_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // cond bit that picks the remainder over the quotient for a divide
    localparam int COND_DIV_REM = 0;

    // cond bit that marks a memory op as a store, clear means load
    localparam int COND_MEM_STORE = 2;

    // =====================================================================
    // micro-op as it arrives from EX2
    // =====================================================================

    typedef struct packed {
        logic       ins_div;
        logic       ins_mem;
        logic [3:0] cond;
        logic [1:0] spare;
    } uop_t;

endpackage

// File: divider.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module divider (
    input  logic          clk,
    input  logic          aresetn,
    input  logic          flush,
    input  logic          div_start,
    input  wb_pkg::data_t dividend,
    input  wb_pkg::data_t divisor,
    output wb_pkg::data_t quotient,
    output wb_pkg::data_t remainder,
    output logic          busy,
    output logic          div_ready
);
    import wb_pkg::*;

    localparam int W     = `WB_DATA_WIDTH;
    localparam int CNT_W = $clog2(`WB_DIV_ITERS + 1);

    logic [CNT_W-1:0] iter_cnt;
    logic             iter_done;

    // dividend bits leave at the top of q_work while quotient bits enter below
    data_t            q_work;
    data_t            d_work;
    data_t            r_work;
    logic [W:0]       r_shift;
    logic [W:0]       r_trial;
    logic             sub_ok;

    assign iter_done = (iter_cnt == CNT_W'(`WB_DIV_ITERS));

    // one restoring step, a zero divisor always subtracts and so yields
    // an all-ones quotient with the dividend left as the remainder
    assign r_shift = {r_work, q_work[W-1]};
    assign r_trial = r_shift - {1'b0, d_work};
    assign sub_ok  = (r_shift >= {1'b0, d_work});

    // =====================================================================
    // control
    // =====================================================================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            busy      <= 1'b0;
            div_ready <= 1'b0;
            iter_cnt  <= '0;
        end else if (flush) begin
            busy      <= 1'b0;
            div_ready <= 1'b0;
            iter_cnt  <= '0;
        end else if (busy) begin
            if (iter_done) begin
                busy      <= 1'b0;
                div_ready <= 1'b1;
            end else begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end else begin
            div_ready <= 1'b0;
            if (div_start) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end
        end
    end

    // =====================================================================
    // shift-subtract datapath
    // =====================================================================

    always_ff @(posedge clk) begin
        if (!busy && div_start) begin
            q_work <= dividend;
            d_work <= divisor;
            r_work <= '0;
        end else if (busy && !iter_done) begin
            q_work <= {q_work[W-2:0], sub_ok};
            r_work <= sub_ok ? r_trial[W-1:0] : r_shift[W-1:0];
        end
        // results stay put until the next division finishes
        if (busy && iter_done && !flush) begin
            quotient  <= q_work;
            remainder <= r_work;
        end
    end

endmodule

// File: dcache_model.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module dcache_model (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic                             mem_req,
    input  logic                             mem_we,
    input  logic [$clog2(`WB_MEM_WORDS)-1:0] mem_addr,
    input  wb_pkg::data_t                    mem_wdata,
    output wb_pkg::data_t                    dcache_data,
    output logic                             dcache_ready
);
    import wb_pkg::*;

    data_t mem [`WB_MEM_WORDS];
    logic  load_req;

    assign load_req = mem_req && !mem_we;

    // =====================================================================
    // word array, a store lands on the request edge
    // =====================================================================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < `WB_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_req && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // =====================================================================
    // load response, one cycle after the request
    // =====================================================================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            dcache_ready <= 1'b0;
        end else begin
            dcache_ready <= load_req;
        end
    end

    // load data holds until the next load replaces it
    always_ff @(posedge clk) begin
        if (load_req) begin
            dcache_data <= mem[mem_addr];
        end
    end

endmodule

// File: ex2_wb.sv
`timescale 1ns/1ps

module ex2_wb (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              flush,

    input  wb_pkg::uop_t      uop0,
    input  wb_pkg::uop_t      uop1,
    input  wb_pkg::data_t     ex2_result0,
    input  wb_pkg::data_t     ex2_result1,
    input  logic              ex2_result0_valid,
    input  logic              ex2_result1_valid,
    input  wb_pkg::reg_addr_t ex_rd0,
    input  wb_pkg::reg_addr_t ex_rd1,

    input  wb_pkg::data_t     quotient,
    input  wb_pkg::data_t     remainder,
    input  logic              div_ready,
    input  wb_pkg::data_t     dcache_data,
    input  logic              dcache_ready,

    output wb_pkg::data_t     wb_data0,
    output wb_pkg::data_t     wb_data1,
    output wb_pkg::reg_addr_t wb_rd0,
    output wb_pkg::reg_addr_t wb_rd1,
    output logic              wb_we0,
    output logic              wb_we1,
    output logic              wb_valid0,
    output logic              wb_valid1
);
    import wb_pkg::*;

    logic  sel_we0;
    logic  sel_we1;
    data_t sel_data0;
    data_t sel_data1;

    // =====================================================================
    // writeback source selection, ALU result first, then divide, then load
    // =====================================================================

    function automatic logic lane_select(
        input  uop_t  uop,
        input  logic  res_valid,
        input  data_t res,
        output data_t data
    );
        logic we;
        we = 1'b0;
        data = '0;
        if (res_valid) begin
            we = 1'b1;
            data = res;
        end else if (uop.ins_div) begin
            // the divide op stays parked here until the divider reports done
            we = div_ready;
            data = uop.cond[COND_DIV_REM] ? remainder : quotient;
        end else if (uop.ins_mem && !uop.cond[COND_MEM_STORE]) begin
            we = dcache_ready;
            data = dcache_data;
        end
        return we;
    endfunction

    always_comb begin
        sel_we0 = lane_select(uop0, ex2_result0_valid, ex2_result0, sel_data0);
        sel_we1 = lane_select(uop1, ex2_result1_valid, ex2_result1, sel_data1);
    end

    // =====================================================================
    // EX2/WB pipeline register
    // =====================================================================

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            wb_data0  <= '0;
            wb_data1  <= '0;
            wb_rd0    <= '0;
            wb_rd1    <= '0;
            wb_we0    <= 1'b0;
            wb_we1    <= 1'b0;
            wb_valid0 <= 1'b0;
            wb_valid1 <= 1'b0;
        end else begin
            // a lane with nothing to write presents all zeros
            wb_data0  <= sel_we0 ? sel_data0 : '0;
            wb_rd0    <= sel_we0 ? ex_rd0 : '0;
            wb_we0    <= sel_we0;
            wb_valid0 <= sel_we0;
            wb_data1  <= sel_we1 ? sel_data1 : '0;
            wb_rd1    <= sel_we1 ? ex_rd1 : '0;
            wb_we1    <= sel_we1;
            wb_valid1 <= sel_we1;
        end
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module regfile (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              we0,
    input  logic              we1,
    input  wb_pkg::reg_addr_t waddr0,
    input  wb_pkg::reg_addr_t waddr1,
    input  wb_pkg::data_t     wdata0,
    input  wb_pkg::data_t     wdata1,
    input  wb_pkg::reg_addr_t raddr0,
    input  wb_pkg::reg_addr_t raddr1,
    output wb_pkg::data_t     rdata0,
    output wb_pkg::data_t     rdata1
);
    import wb_pkg::*;

    data_t regs [`WB_NUM_REGS];

    // =====================================================================
    // write ports
    // =====================================================================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < `WB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
            // lane 1 is younger, so its write is issued last and wins a tie
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // =====================================================================
    // read ports
    // =====================================================================

    // entry 0 is never written after reset, so it reads zero
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

endmodule

// File: ex2_wb_top.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module ex2_wb_top (
    input  logic                             clk,
    input  logic                             aresetn,
    input  logic                             flush,

    input  logic                             div_start,
    input  wb_pkg::data_t                    dividend,
    input  wb_pkg::data_t                    divisor,

    input  logic                             mem_req,
    input  logic                             mem_we,
    input  logic [$clog2(`WB_MEM_WORDS)-1:0] mem_addr,
    input  wb_pkg::data_t                    mem_wdata,

    input  wb_pkg::uop_t                     uop0,
    input  wb_pkg::uop_t                     uop1,
    input  wb_pkg::data_t                    ex2_result0,
    input  wb_pkg::data_t                    ex2_result1,
    input  logic                             ex2_result0_valid,
    input  logic                             ex2_result1_valid,
    input  wb_pkg::reg_addr_t                ex_rd0,
    input  wb_pkg::reg_addr_t                ex_rd1,

    input  wb_pkg::reg_addr_t                rf_raddr0,
    input  wb_pkg::reg_addr_t                rf_raddr1,
    output wb_pkg::data_t                    rf_rdata0,
    output wb_pkg::data_t                    rf_rdata1,

    output logic                             busy,
    output wb_pkg::data_t                    wb_data0,
    output wb_pkg::data_t                    wb_data1,
    output wb_pkg::reg_addr_t                wb_rd0,
    output wb_pkg::reg_addr_t                wb_rd1,
    output logic                             wb_we0,
    output logic                             wb_we1,
    output logic                             wb_valid0,
    output logic                             wb_valid1
);
    import wb_pkg::*;

    data_t quotient;
    data_t remainder;
    logic  div_ready;
    data_t dcache_data;
    logic  dcache_ready;

    // =========================================================================
    // execution resources shared by both lanes
    // =========================================================================

    divider u_divider (
        .clk       (clk),
        .aresetn   (aresetn),
        .flush     (flush),
        .div_start (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .busy      (busy),
        .div_ready (div_ready)
    );

    dcache_model u_dcache (
        .clk          (clk),
        .aresetn      (aresetn),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .dcache_data  (dcache_data),
        .dcache_ready (dcache_ready)
    );

    // =========================================================================
    // writeback and architectural state
    // =========================================================================

    ex2_wb u_ex2_wb (
        .clk               (clk),
        .aresetn           (aresetn),
        .flush             (flush),
        .uop0              (uop0),
        .uop1              (uop1),
        .ex2_result0       (ex2_result0),
        .ex2_result1       (ex2_result1),
        .ex2_result0_valid (ex2_result0_valid),
        .ex2_result1_valid (ex2_result1_valid),
        .ex_rd0            (ex_rd0),
        .ex_rd1            (ex_rd1),
        .quotient          (quotient),
        .remainder         (remainder),
        .div_ready         (div_ready),
        .dcache_data       (dcache_data),
        .dcache_ready      (dcache_ready),
        .wb_data0          (wb_data0),
        .wb_data1          (wb_data1),
        .wb_rd0            (wb_rd0),
        .wb_rd1            (wb_rd1),
        .wb_we0            (wb_we0),
        .wb_we1            (wb_we1),
        .wb_valid0         (wb_valid0),
        .wb_valid1         (wb_valid1)
    );

    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .we0     (wb_we0),
        .we1     (wb_we1),
        .waddr0  (wb_rd0),
        .waddr1  (wb_rd1),
        .wdata0  (wb_data0),
        .wdata1  (wb_data1),
        .raddr0  (rf_raddr0),
        .raddr1  (rf_raddr1),
        .rdata0  (rf_rdata0),
        .rdata1  (rf_rdata1)
    );

endmodule

// File: wb_properties.sv
`timescale 1ns/1ps

module wb_properties (
    input logic clk,
    input logic aresetn,
    input logic flush,
    input logic ex2_result0_valid,
    input logic ex2_result1_valid,
    input logic div_ready,
    input logic dcache_ready,
    input logic wb_we0,
    input logic wb_we1,
    input logic wb_valid0,
    input logic wb_valid1
);

    // =========================================================================
    // writeback output rules
    // =========================================================================

    // a write needs its valid flag and a source that was ready on the edge before
    we_valid0: assert property (@(posedge clk) disable iff (!aresetn)
        wb_we0 |-> wb_valid0 && $past(ex2_result0_valid || div_ready || dcache_ready))
        else $error("lane 0 write enable without valid or without a ready source");

    we_valid1: assert property (@(posedge clk) disable iff (!aresetn)
        wb_we1 |-> wb_valid1 && $past(ex2_result1_valid || div_ready || dcache_ready))
        else $error("lane 1 write enable without valid or without a ready source");

    // a flush sampled on an edge clears the whole register on that edge
    flush_clears: assert property (@(posedge clk) disable iff (!aresetn)
        flush |=> !wb_we0 && !wb_we1 && !wb_valid0 && !wb_valid1)
        else $error("writeback still active in the cycle after flush");

    div_ready_pulse: assert property (@(posedge clk) disable iff (!aresetn)
        div_ready |=> !div_ready)
        else $error("div_ready held high for two cycles");

    no_write_in_reset: assert property (@(posedge clk)
        !aresetn |=> !wb_we0 && !wb_we1)
        else $error("write enable high while in reset");

endmodule

bind ex2_wb wb_properties u_wb_properties (.*);

// File: tb_ex2_wb.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module tb_ex2_wb;
    import wb_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DIV_RUNS = 6;
    // reset, ALU, division, load/store and flush phases, in cycles
    localparam int TEST_CYCLES = 20 + 20 + (DIV_RUNS + 2) * 42 + 60 + 100;
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

    logic clk, aresetn, flush, div_start, mem_req, mem_we;
    logic ex2_result0_valid, ex2_result1_valid;
    logic [7:0] mem_addr;
    data_t dividend, divisor, mem_wdata, ex2_result0, ex2_result1;
    data_t rf_rdata0, rf_rdata1, wb_data0, wb_data1;
    uop_t uop0, uop1;
    reg_addr_t ex_rd0, ex_rd1, rf_raddr0, rf_raddr1, wb_rd0, wb_rd1;
    logic busy, wb_we0, wb_we1, wb_valid0, wb_valid1;
    int errors, tests_failed;

    ex2_wb_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // the register file is written on the edge this task waits for
    task automatic read_check(input reg_addr_t a0, input data_t e0,
                              input reg_addr_t a1, input data_t e1);
        @(posedge clk);
        rf_raddr0 <= a0;
        rf_raddr1 <= a1;
        @(negedge clk);
        check("rf_rdata0", rf_rdata0, e0);
        check("rf_rdata1", rf_rdata1, e1);
    endtask

    task automatic alu_pair(input reg_addr_t rd0, input data_t d0, input reg_addr_t rd1,
                            input data_t d1, input logic do_flush);
        @(posedge clk);
        ex2_result0_valid <= 1'b1;
        ex2_result1_valid <= 1'b1;
        ex2_result0 <= d0;
        ex2_result1 <= d1;
        ex_rd0 <= rd0;
        ex_rd1 <= rd1;
        flush <= do_flush;
        @(posedge clk);
        ex2_result0_valid <= 1'b0;
        ex2_result1_valid <= 1'b0;
        flush <= 1'b0;
        @(negedge clk);
        check("wb_we0", 32'(wb_we0), 32'(!do_flush));
        check("wb_we1", 32'(wb_we1), 32'(!do_flush));
        check("wb_valid0", 32'(wb_valid0), 32'(!do_flush));
        check("wb_valid1", 32'(wb_valid1), 32'(!do_flush));
        if (!do_flush) begin
            check("wb_data0", wb_data0, d0);
            check("wb_rd0", 32'(wb_rd0), 32'(rd0));
            check("wb_data1", wb_data1, d1);
            check("wb_rd1", 32'(wb_rd1), 32'(rd1));
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check("wb_we0", 32'(wb_we0), 0);
        check("wb_we1", 32'(wb_we1), 0);
        check("wb_valid0", 32'(wb_valid0), 0);
        check("wb_valid1", 32'(wb_valid1), 0);
        check("busy", 32'(busy), 0);
        repeat (4) read_check(6'($urandom()), '0, 6'($urandom()), '0);
        report("reset", e0);
    endtask

    task automatic test_alu();
        int e0;
        reg_addr_t a, b;
        data_t x, y;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = 6'(1 + $urandom() % 31);
            b = 6'(32 + $urandom() % 31);
            x = $urandom();
            y = $urandom();
            alu_pair(a, x, b, y, 1'b0);
            read_check(a, x, b, y);
        end
        // same destination on both lanes, the younger lane 1 must win
        x = $urandom();
        y = $urandom();
        alu_pair(6'd40, x, 6'd40, y, 1'b0);
        read_check(6'd40, y, 6'd40, y);
        alu_pair(6'd0, x, 6'd41, y, 1'b0);
        read_check(6'd0, '0, 6'd41, y);
        report("alu writeback", e0);
    endtask

    task automatic run_div(input int lane, input logic rem, input data_t a, input data_t b,
                           input reg_addr_t rd);
        uop_t u;
        data_t exp;
        int n;
        u = '0;
        u.ins_div = 1'b1;
        u.cond[COND_DIV_REM] = rem;
        if (b == 0) exp = rem ? a : '1;
        else exp = rem ? a % b : a / b;
        @(posedge clk);
        if (lane == 0) begin
            uop0 <= u;
            ex_rd0 <= rd;
        end else begin
            uop1 <= u;
            ex_rd1 <= rd;
        end
        dividend <= a;
        divisor <= b;
        div_start <= 1'b1;
        @(posedge clk);
        div_start <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (!uut.div_ready && n < 100);
        check("div_ready latency", n, `WB_DIV_ITERS + 1);
        @(negedge clk);
        check(lane == 0 ? "wb_data0" : "wb_data1", lane == 0 ? wb_data0 : wb_data1, exp);
        check(lane == 0 ? "wb_we0" : "wb_we1", 32'(lane == 0 ? wb_we0 : wb_we1), 1);
        @(posedge clk);
        uop0 <= '0;
        uop1 <= '0;
        read_check(rd, exp, rd, exp);
    endtask

    task automatic test_div();
        int e0;
        e0 = errors;
        for (int i = 0; i < DIV_RUNS; i++) begin
            run_div(i % 2, i % 2 == 0, $urandom(), $urandom() >> (i * 5), 6'(10 + i));
        end
        run_div(0, 1'b0, 32'h1234_5678, '0, 6'd20);
        run_div(1, 1'b1, 32'h8765_4321, '0, 6'd21);
        report("division", e0);
    endtask

    task automatic mem_access(input logic we, input logic [7:0] addr, input data_t wdata,
                              input int lane, input reg_addr_t rd);
        uop_t u;
        uop_t st;
        u = '0;
        u.ins_mem = 1'b1;
        u.cond[COND_MEM_STORE] = we;
        // the other lane holds a store, which must not pick up load data
        st = '0;
        st.ins_mem = 1'b1;
        st.cond[COND_MEM_STORE] = 1'b1;
        @(posedge clk);
        if (lane == 0) begin
            uop0 <= u;
            uop1 <= st;
            ex_rd0 <= rd;
        end else begin
            uop0 <= st;
            uop1 <= u;
            ex_rd1 <= rd;
        end
        mem_req <= 1'b1;
        mem_we <= we;
        mem_addr <= addr;
        mem_wdata <= wdata;
        @(posedge clk);
        mem_req <= 1'b0;
        @(negedge clk);
        check("wb_we0", 32'(wb_we0), 0);
        check("wb_we1", 32'(wb_we1), 0);
        @(negedge clk);
        check(lane == 0 ? "wb_we0" : "wb_we1", 32'(lane == 0 ? wb_we0 : wb_we1), 32'(!we));
        check(lane == 0 ? "wb_we1" : "wb_we0", 32'(lane == 0 ? wb_we1 : wb_we0), 0);
        if (!we) begin
            check(lane == 0 ? "wb_data0" : "wb_data1",
                  lane == 0 ? wb_data0 : wb_data1, wdata);
        end
        @(posedge clk);
        uop0 <= '0;
        uop1 <= '0;
    endtask

    task automatic test_mem();
        int e0;
        logic [7:0] base;
        data_t words [4];
        e0 = errors;
        base = 8'($urandom());
        for (int i = 0; i < 4; i++) begin
            words[i] = $urandom();
            mem_access(1'b1, base + 8'(i * 37), words[i], 0, 6'd50);
        end
        for (int i = 0; i < 4; i++) begin
            mem_access(1'b0, base + 8'(i * 37), words[i], i % 2, 6'(24 + i));
            read_check(6'(24 + i), words[i], 6'd50, '0);
        end
        report("load/store", e0);
    endtask

    task automatic test_flush();
        int e0;
        uop_t u;
        e0 = errors;
        alu_pair(6'd60, 32'hcafe_0001, 6'd61, 32'hcafe_0002, 1'b0);
        alu_pair(6'd60, 32'hdead_0001, 6'd61, 32'hdead_0002, 1'b1);
        read_check(6'd60, 32'hcafe_0001, 6'd61, 32'hcafe_0002);
        u = '0;
        u.ins_div = 1'b1;
        @(posedge clk);
        uop0 <= u;
        ex_rd0 <= 6'd62;
        dividend <= 32'd1000;
        divisor <= 32'd7;
        div_start <= 1'b1;
        @(posedge clk);
        div_start <= 1'b0;
        repeat (10) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check("busy", 32'(busy), 0);
        repeat (40) begin
            @(negedge clk);
            assert (!(uut.div_ready || wb_we0)) else begin
                $display("a write followed a flushed division at %0t", $time);
                errors++;
            end
        end
        @(posedge clk);
        uop0 <= '0;
        read_check(6'd62, '0, 6'd0, '0);
        report("flush", e0);
    endtask

    initial begin
        void'($urandom(34));
        {aresetn, flush, div_start, mem_req, mem_we} = '0;
        {ex2_result0_valid, ex2_result1_valid} = '0;
        {dividend, divisor, mem_wdata, ex2_result0, ex2_result1} = '0;
        {uop0, uop1, ex_rd0, ex_rd1, rf_raddr0, rf_raddr1, mem_addr} = '0;
        errors = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        aresetn <= 1'b1;
        @(negedge clk);
        test_reset();
        test_alu();
        test_div();
        test_mem();
        test_flush();
        $display("tests run 5, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
wb_pkg.sv
divider.sv
dcache_model.sv
ex2_wb.sv
regfile.sv
ex2_wb_top.sv
wb_properties.sv
tb_ex2_wb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the EX2/WB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_ex2_wb \
    --Mdir obj_dir -o sim_tb_ex2_wb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb_ex2_wb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
